/* tests/led_atr_stimulus.txt */
# op 1 write: addr data status | op 2 read: addr data status (status 4 = no ack)
# op 3 db step: db_state expect_write word ack_delay | op 4 late write: - - word ack_delay
1 2000 0 0 0
1 2400 0 0 0
1 2800 0 0 0
1 2c00 0 0 0
1 3000 5 0 0
2 3000 5 0 0
1 3004 a 0 0
2 3004 a 0 0
1 3000 0 0 0
1 3004 0 0 0
1 2004 ff 0 0
2 2004 7 0 0
1 2002 1 1 0
2 2002 0 1 0
1 3008 1 1 0
2 3008 0 1 0
1 1000 1 4 0
2 4000 0 4 0
1 2048 1 0 0
1 2448 2 0 0
1 2848 4 0 0
1 2c48 3 0 0
1 2168 6 0 0
1 2568 5 0 0
1 2968 0 0 0
1 2d68 7 0 0
3 12 1 711 2
3 5a 1 e2e 2
3 00 1 0 2
1 2404 3 0 0
1 2808 5 0 0
1 2c0c 6 0 0
1 3000 f 0 0
3 e4 1 d58 2
3 e5 1 d5f 2
3 00 1 0 2
1 3004 e 0 0
3 55 1 7 2
3 15 0 0 0
3 14 1 0 2
3 00 0 0 0
1 3004 0 0 0
1 3000 0 0 0
3 12 1 711 3c
3 5a 0 0 0
3 00 0 0 0
3 5a 0 0 0
4 0 0 e2e 2

/* tb.f */
+incdir+rtl
rtl/led_atr_pkg.sv
rtl/led_atr_regs.sv
rtl/led_atr_channel.sv
rtl/led_cpld_writer.sv
rtl/led_atr_control.sv
tests/tb_clock_gen.sv
tests/led_atr_control_tb.sv

/* Bender.yml */
package:
  name: led_atr_control

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/led_atr_pkg.sv
      - rtl/led_atr_regs.sv
      - rtl/led_atr_channel.sv
      - rtl/led_cpld_writer.sv
      - rtl/led_atr_control.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clock_gen.sv
      - tests/led_atr_control_tb.sv

/* tests/led_atr_control_tb.sv */
// replays tests/led_atr_stimulus.txt against led_atr_control
// the CPLD side is a model that acks every write after a delay from the file
// run from the project root so the stimulus path resolves

`timescale 1ns/1ps
`default_nettype none

`include "led_atr_settings.svh"

module led_atr_control_tb import led_atr_pkg::*; ();

  // wait limits in clock cycles
  localparam int reply_timeout = 10;
  localparam int write_timeout = 20;
  localparam int quiet_cycles  = 10;
  localparam int late_timeout  = 100;
  localparam int reset_timeout = 50;

  logic                        ctrlport_clk;
  logic                        ctrlport_rst;
  logic                        s_ctrlport_req_wr;
  logic                        s_ctrlport_req_rd;
  logic [`CTRLPORT_ADDR_W-1:0] s_ctrlport_req_addr;
  logic [`CTRLPORT_DATA_W-1:0] s_ctrlport_req_data;
  logic                        s_ctrlport_resp_ack;
  ctrl_status_e                s_ctrlport_resp_status;
  logic [`CTRLPORT_DATA_W-1:0] s_ctrlport_resp_data;
  logic [`LED_ATR_INDEX_W-1:0] db_state;
  logic                        m_ctrlport_req_wr;
  logic                        m_ctrlport_req_rd;
  logic [`CTRLPORT_ADDR_W-1:0] m_ctrlport_req_addr;
  logic [`CTRLPORT_DATA_W-1:0] m_ctrlport_req_data;
  logic [3:0]                  m_ctrlport_req_byte_en;
  logic                        m_ctrlport_resp_ack;

  // CPLD model state
  int                          wr_count;
  logic [`CTRLPORT_DATA_W-1:0] wr_data;
  int                          ack_delay;
  int                          ack_count;

  int errors;
  int checks;

  tb_clock_gen i_tb_clock_gen (
    .clk (ctrlport_clk),
    .rst (ctrlport_rst)
  );

  led_atr_control i_led_atr_control (
    .ctrlport_clk           (ctrlport_clk),
    .ctrlport_rst           (ctrlport_rst),
    .s_ctrlport_req_wr      (s_ctrlport_req_wr),
    .s_ctrlport_req_rd      (s_ctrlport_req_rd),
    .s_ctrlport_req_addr    (s_ctrlport_req_addr),
    .s_ctrlport_req_data    (s_ctrlport_req_data),
    .s_ctrlport_resp_ack    (s_ctrlport_resp_ack),
    .s_ctrlport_resp_status (s_ctrlport_resp_status),
    .s_ctrlport_resp_data   (s_ctrlport_resp_data),
    .db_state               (db_state),
    .m_ctrlport_req_wr      (m_ctrlport_req_wr),
    .m_ctrlport_req_rd      (m_ctrlport_req_rd),
    .m_ctrlport_req_addr    (m_ctrlport_req_addr),
    .m_ctrlport_req_data    (m_ctrlport_req_data),
    .m_ctrlport_req_byte_en (m_ctrlport_req_byte_en),
    .m_ctrlport_resp_ack    (m_ctrlport_resp_ack)
  );

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  // --------------------
  // CPLD model
  // --------------------
  always @(posedge ctrlport_clk) begin
    if (m_ctrlport_req_wr) begin
      wr_count++;
      wr_data   = m_ctrlport_req_data;
      ack_count = ack_delay;
      compare_value("cpld address", m_ctrlport_req_addr, `LED_CPLD_REG_ADDR);
      compare_value("cpld byte enable", m_ctrlport_req_byte_en, 4'hf);
      compare_value("cpld read strobe", m_ctrlport_req_rd, 1'b0);
    end
    #1;
    m_ctrlport_resp_ack = 1'b0;
    // ack lands ack_delay edges after the request
    if (ack_count > 0) begin
      ack_count--;
      if (ack_count == 0) begin
        m_ctrlport_resp_ack = 1'b1;
      end
    end
  end

  // --------------------
  // register port access
  // --------------------
  // status 4 in the file means no ack expected
  task automatic reg_access(input logic is_wr, input logic [31:0] addr,
                            input logic [31:0] data_in, input logic [31:0] exp_status);
    int   cycles;
    logic got_ack;
    @(posedge ctrlport_clk);
    #1;
    s_ctrlport_req_wr   = is_wr;
    s_ctrlport_req_rd   = !is_wr;
    s_ctrlport_req_addr = addr[`CTRLPORT_ADDR_W-1:0];
    s_ctrlport_req_data = is_wr ? data_in : 32'h0;
    @(posedge ctrlport_clk);
    #1;
    s_ctrlport_req_wr = 1'b0;
    s_ctrlport_req_rd = 1'b0;
    got_ack = 1'b0;
    cycles  = 0;
    while (!got_ack && cycles < reply_timeout) begin
      @(negedge ctrlport_clk);
      cycles++;
      if (s_ctrlport_resp_ack) begin
        got_ack = 1'b1;
      end
    end
    if (exp_status == 4) begin
      compare_value("ack outside window", got_ack, 1'b0);
    end else if (!got_ack) begin
      errors++;
      $display("timeout: register port never answered the access to address %h", addr);
    end else begin
      // writes answer one cycle after the strobe, reads three
      compare_value("ack latency", cycles, is_wr ? 1 : 3);
      compare_value("response status", s_ctrlport_resp_status, exp_status);
      if (!is_wr) begin
        compare_value("read data", s_ctrlport_resp_data, data_in);
      end
    end
  endtask

  // --------------------
  // CPLD write observation
  // --------------------
  task automatic wait_for_write(input int base, input logic [31:0] exp_word, input int limit);
    int          cycles;
    logic [31:0] first_word;
    cycles = 0;
    while (wr_count == base && cycles < limit) begin
      @(negedge ctrlport_clk);
      cycles++;
    end
    if (wr_count == base) begin
      errors++;
      $display("timeout: no CPLD write arrived, expected word %h", exp_word);
    end else begin
      first_word = wr_data;
      // any further write in this window is one too many
      cycles = 0;
      while (cycles < quiet_cycles) begin
        @(negedge ctrlport_clk);
        cycles++;
      end
      compare_value("cpld write count", wr_count - base, 1);
      compare_value("cpld word", first_word, exp_word);
    end
  endtask

  task automatic check_quiet(input int base);
    int cycles;
    cycles = 0;
    while (cycles < quiet_cycles) begin
      @(negedge ctrlport_clk);
      cycles++;
    end
    compare_value("unexpected cpld writes", wr_count - base, 0);
  endtask

  task automatic db_step(input logic [31:0] value, input logic [31:0] expect_wr,
                         input logic [31:0] exp_word, input logic [31:0] delay);
    int base;
    base = wr_count;
    if (expect_wr != 0) begin
      ack_delay = delay;
    end
    @(posedge ctrlport_clk);
    #1;
    db_state = value[`LED_ATR_INDEX_W-1:0];
    if (expect_wr != 0) begin
      wait_for_write(base, exp_word, write_timeout);
    end else begin
      check_quiet(base);
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int          fd;
    int          n;
    int          cycles;
    string       line;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    s_ctrlport_req_wr   = 1'b0;
    s_ctrlport_req_rd   = 1'b0;
    s_ctrlport_req_addr = '0;
    s_ctrlport_req_data = '0;
    db_state            = '0;
    m_ctrlport_resp_ack = 1'b0;
    wr_count  = 0;
    wr_data   = '0;
    ack_delay = 1;
    ack_count = 0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    #1;
    while (ctrlport_rst && cycles < reset_timeout) begin
      @(posedge ctrlport_clk);
      cycles++;
    end
    if (ctrlport_rst) begin
      errors++;
      $display("timeout: reset never released");
    end
    fd = $fopen("tests/led_atr_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // comment and blank lines do not parse as five fields
        n = $sscanf(line, "%h %h %h %h %h", op, a, b, c, d);
        if (n == 5) begin
          case (op)
            1: reg_access(1'b1, a, b, c);
            2: reg_access(1'b0, a, b, c);
            3: db_step(a, b, c, d);
            4: begin
              ack_delay = d;
              wait_for_write(wr_count, c, late_timeout);
            end
            default: begin
              errors++;
              $display("unknown operation %h in the stimulus file", op);
            end
          endcase
        end
      end
      $fclose(fd);
    end
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// clock and reset source for the testbench, 4 ns period
// reset stays high for the first 8 rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // synchronous reset, released just after an edge
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

/* rtl/led_atr_control.sv */
// LED ATR control for a four-channel daughterboard
// db_state change reaches m_ctrlport_req_wr four cycles later when the writer is idle
// CPLD response status and data are not used

`timescale 1ns/1ps
`default_nettype none

`include "led_atr_settings.svh"

module led_atr_control import led_atr_pkg::*; (
  input  logic                          ctrlport_clk,
  input  logic                          ctrlport_rst,
  // slave control port
  input  logic                          s_ctrlport_req_wr,
  input  logic                          s_ctrlport_req_rd,
  input  logic [`CTRLPORT_ADDR_W-1:0]   s_ctrlport_req_addr,
  input  logic [`CTRLPORT_DATA_W-1:0]   s_ctrlport_req_data,
  output logic                          s_ctrlport_resp_ack,
  output ctrl_status_e                  s_ctrlport_resp_status,
  output logic [`CTRLPORT_DATA_W-1:0]   s_ctrlport_resp_data,
  // daughterboard tx/rx state, two bits per channel
  input  logic [`LED_ATR_INDEX_W-1:0]   db_state,
  // master control port toward the CPLD
  output logic                          m_ctrlport_req_wr,
  output logic                          m_ctrlport_req_rd,
  output logic [`CTRLPORT_ADDR_W-1:0]   m_ctrlport_req_addr,
  output logic [`CTRLPORT_DATA_W-1:0]   m_ctrlport_req_data,
  output logic [3:0]                    m_ctrlport_req_byte_en,
  input  logic                          m_ctrlport_resp_ack
);

  // table access from the register block
  logic [`LED_NUM_CH-1:0]      table_wr_en;
  logic [`LED_ATR_INDEX_W-1:0] table_addr;
  led_state_t                  table_wr_data;
  led_state_t [`LED_NUM_CH-1:0] table_rd_data;
  // per-channel scheme bits
  logic [`LED_NUM_CH-1:0]      atr_disable;
  logic [`LED_NUM_CH-1:0]      atr_classic;
  // looked-up LED states
  led_state_t [`LED_NUM_CH-1:0] led_state;

  // --------------------
  // register block
  led_atr_regs i_led_atr_regs (
    .ctrlport_clk           (ctrlport_clk),
    .ctrlport_rst           (ctrlport_rst),
    .s_ctrlport_req_wr      (s_ctrlport_req_wr),
    .s_ctrlport_req_rd      (s_ctrlport_req_rd),
    .s_ctrlport_req_addr    (s_ctrlport_req_addr),
    .s_ctrlport_req_data    (s_ctrlport_req_data),
    .table_rd_data          (table_rd_data),
    .s_ctrlport_resp_ack    (s_ctrlport_resp_ack),
    .s_ctrlport_resp_status (s_ctrlport_resp_status),
    .s_ctrlport_resp_data   (s_ctrlport_resp_data),
    .table_wr_en            (table_wr_en),
    .table_addr             (table_addr),
    .table_wr_data          (table_wr_data),
    .atr_disable            (atr_disable),
    .atr_classic            (atr_classic)
  );

  // --------------------
  // channels, each sees its own db_state pair
  for (genvar n = 0; n < `LED_NUM_CH; n++) begin : g_channel
    led_atr_channel i_led_atr_channel (
      .ctrlport_clk  (ctrlport_clk),
      .table_wr_en   (table_wr_en[n]),
      .table_addr    (table_addr),
      .table_wr_data (table_wr_data),
      .atr_disable   (atr_disable[n]),
      .atr_classic   (atr_classic[n]),
      .db_state      (db_state),
      .db_pair       (db_state[2*n +: 2]),
      .table_rd_data (table_rd_data[n]),
      .led_state     (led_state[n])
    );
  end

  // --------------------
  // CPLD writer
  led_cpld_writer i_led_cpld_writer (
    .ctrlport_clk           (ctrlport_clk),
    .ctrlport_rst           (ctrlport_rst),
    .led_state              (led_state),
    .m_ctrlport_resp_ack    (m_ctrlport_resp_ack),
    .m_ctrlport_req_wr      (m_ctrlport_req_wr),
    .m_ctrlport_req_rd      (m_ctrlport_req_rd),
    .m_ctrlport_req_addr    (m_ctrlport_req_addr),
    .m_ctrlport_req_data    (m_ctrlport_req_data),
    .m_ctrlport_req_byte_en (m_ctrlport_req_byte_en)
  );

endmodule

`default_nettype wire

/* rtl/led_cpld_writer.sv */
// pushes the packed LED word to the CPLD whenever it changes
// one write outstanding at a time, changes during a transfer are not queued
// only the newest word goes out after the ack, response status is ignored

`timescale 1ns/1ps
`default_nettype none

`include "led_atr_settings.svh"

module led_cpld_writer import led_atr_pkg::*; (
  input  logic                          ctrlport_clk,
  input  logic                          ctrlport_rst,
  input  led_state_t [`LED_NUM_CH-1:0]  led_state,
  input  logic                          m_ctrlport_resp_ack,
  output logic                          m_ctrlport_req_wr,
  output logic                          m_ctrlport_req_rd,
  output logic [`CTRLPORT_ADDR_W-1:0]   m_ctrlport_req_addr,
  output logic [`CTRLPORT_DATA_W-1:0]   m_ctrlport_req_data,
  output logic [3:0]                    m_ctrlport_req_byte_en
);

  writer_state_e               state;
  logic [`CTRLPORT_DATA_W-1:0] packed_word;
  logic [`CTRLPORT_DATA_W-1:0] led_word;
  // last word handed to the CPLD
  logic [`CTRLPORT_DATA_W-1:0] sent_word;

  // channel n bit k lands on word bit 3n+k
  always_comb begin
    packed_word = '0;
    for (int n = 0; n < `LED_NUM_CH; n++) begin
      packed_word[`LED_SIZE*n +: `LED_SIZE] = led_state[n];
    end
  end

  // --------------------
  // change detect and FSM
  // --------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state             <= idle;
      m_ctrlport_req_wr <= 1'b0;
      led_word          <= '0;
      sent_word         <= '0;
    end else begin
      led_word          <= packed_word;
      m_ctrlport_req_wr <= 1'b0;
      case (state)
        idle: begin
          if (led_word != sent_word) begin
            m_ctrlport_req_wr <= 1'b1;
            sent_word         <= led_word;
            state             <= wait_ack;
          end
        end
        wait_ack: begin
          // newest word gets compared again once back in idle
          if (m_ctrlport_resp_ack) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // fixed request fields, data held until the next pulse
  assign m_ctrlport_req_rd      = 1'b0;
  assign m_ctrlport_req_addr    = `LED_CPLD_REG_ADDR;
  assign m_ctrlport_req_byte_en = 4'b1111;
  assign m_ctrlport_req_data    = sent_word;

endmodule

`default_nettype wire

/* rtl/led_atr_channel.sv */
// one LED channel, ATR index select plus a 256-entry state table
// table contents are not reset and must be written before use

`timescale 1ns/1ps
`default_nettype none

`include "led_atr_settings.svh"

module led_atr_channel import led_atr_pkg::*; (
  input  logic                        ctrlport_clk,
  input  logic                        table_wr_en,
  input  logic [`LED_ATR_INDEX_W-1:0] table_addr,
  input  led_state_t                  table_wr_data,
  input  logic                        atr_disable,
  input  logic                        atr_classic,
  input  logic [`LED_ATR_INDEX_W-1:0] db_state,
  input  logic [1:0]                  db_pair,
  output led_state_t                  table_rd_data,
  output led_state_t                  led_state
);

  // registered lookup index
  logic [`LED_ATR_INDEX_W-1:0] atr_index;

  // LED states, one per ATR index
  led_state_t state_table [2**`LED_ATR_INDEX_W];

  // --------------------
  // index selection
  // --------------------
  always_ff @(posedge ctrlport_clk) begin
    if (atr_disable) begin
      // single persistent state
      atr_index <= '0;
    end else if (atr_classic) begin
      // only this channel's tx/rx pair
      atr_index <= {{(`LED_ATR_INDEX_W-2){1'b0}}, db_pair};
    end else begin
      // whole daughterboard state
      atr_index <= db_state;
    end
  end

  // --------------------
  // state table
  // --------------------

  // register side, read-first
  always_ff @(posedge ctrlport_clk) begin
    if (table_wr_en) begin
      state_table[table_addr] <= table_wr_data;
    end
    table_rd_data <= state_table[table_addr];
  end

  // lookup side, read only
  always_ff @(posedge ctrlport_clk) begin
    led_state <= state_table[atr_index];
  end

endmodule

`default_nettype wire

/* rtl/led_atr_regs.sv */
// register decoder for the LED ATR window, single-cycle strobes, no back-pressure
// writes ack one cycle after the strobe, reads three cycles after
// addresses outside the window are ignored and never acked

`timescale 1ns/1ps
`default_nettype none

`include "led_atr_settings.svh"

module led_atr_regs import led_atr_pkg::*; (
  input  logic                                ctrlport_clk,
  input  logic                                ctrlport_rst,
  input  logic                                s_ctrlport_req_wr,
  input  logic                                s_ctrlport_req_rd,
  input  logic [`CTRLPORT_ADDR_W-1:0]         s_ctrlport_req_addr,
  input  logic [`CTRLPORT_DATA_W-1:0]         s_ctrlport_req_data,
  input  led_state_t [`LED_NUM_CH-1:0]        table_rd_data,
  output logic                                s_ctrlport_resp_ack,
  output ctrl_status_e                        s_ctrlport_resp_status,
  output logic [`CTRLPORT_DATA_W-1:0]         s_ctrlport_resp_data,
  output logic [`LED_NUM_CH-1:0]              table_wr_en,
  output logic [`LED_ATR_INDEX_W-1:0]         table_addr,
  output led_state_t                          table_wr_data,
  output logic [`LED_NUM_CH-1:0]              atr_disable,
  output logic [`LED_NUM_CH-1:0]              atr_classic
);

  // window bounds
  localparam logic [`CTRLPORT_ADDR_W-1:0] win_lo = `LED_ATR_REG_BASE;
  localparam logic [`CTRLPORT_ADDR_W-1:0] win_hi = `LED_ATR_REG_BASE + `LED_ATR_REG_SIZE;

  // read strobe delay line, lines up with the table output
  logic [1:0]                  rd_pipe;
  logic [`CTRLPORT_ADDR_W-1:0] rd_addr;

  // decode signals
  logic [`CTRLPORT_ADDR_W-1:0] dec_addr;
  logic [`CTRLPORT_ADDR_W-1:0] dec_offset;
  logic                        dec_in_window;
  logic                        dec_is_entry;
  logic                        dec_is_option;
  logic                        dec_is_disable;
  logic [1:0]                  dec_channel;
  ctrl_status_e                dec_status;
  logic [`CTRLPORT_DATA_W-1:0] rd_value;

  // --------------------
  // address decode
  // --------------------

  // write uses the live address, a finishing read its latched one
  assign dec_addr      = s_ctrlport_req_wr ? s_ctrlport_req_addr : rd_addr;
  assign dec_offset    = dec_addr - win_lo;
  assign dec_in_window = (dec_addr >= win_lo) && (dec_addr < win_hi);

  // table entry, word aligned only
  assign dec_is_entry   = dec_in_window && (dec_offset < `LED_ATR_STATE_SPAN) &&
                          (dec_offset[1:0] == 2'b00);
  assign dec_is_option  = dec_in_window && (dec_offset == `LED_ATR_OPTION_OFFSET);
  assign dec_is_disable = dec_in_window && (dec_offset == `LED_ATR_DISABLE_OFFSET);
  // channel sits just above the index bits
  assign dec_channel    = dec_offset[`LED_ATR_INDEX_W+3:`LED_ATR_INDEX_W+2];

  // any other in-window address is a command error
  assign dec_status = (dec_is_entry || dec_is_option || dec_is_disable) ?
                      sts_okay : sts_cmd_err;

  // read-back value, zero extended
  always_comb begin
    rd_value = '0;
    if (dec_is_entry) begin
      rd_value[`LED_SIZE-1:0] = table_rd_data[dec_channel];
    end else if (dec_is_option) begin
      rd_value[`LED_NUM_CH-1:0] = atr_classic;
    end else if (dec_is_disable) begin
      rd_value[`LED_NUM_CH-1:0] = atr_disable;
    end
  end

  // --------------------
  // control state
  // --------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      s_ctrlport_resp_ack <= 1'b0;
      rd_pipe             <= '0;
      table_wr_en         <= '0;
      atr_disable         <= '0;
      atr_classic         <= '0;
    end else begin
      rd_pipe             <= {rd_pipe[0], s_ctrlport_req_rd};
      table_wr_en         <= '0;
      s_ctrlport_resp_ack <= 1'b0;
      if (s_ctrlport_req_wr) begin
        // no ack outside the window
        s_ctrlport_resp_ack <= dec_in_window;
        if (dec_is_entry) begin
          table_wr_en[dec_channel] <= 1'b1;
        end
        if (dec_is_option) begin
          atr_classic <= s_ctrlport_req_data[`LED_NUM_CH-1:0];
        end
        if (dec_is_disable) begin
          atr_disable <= s_ctrlport_req_data[`LED_NUM_CH-1:0];
        end
      end else if (rd_pipe[1]) begin
        s_ctrlport_resp_ack <= dec_in_window;
      end
    end
  end

  // request payload and response contents
  always_ff @(posedge ctrlport_clk) begin
    if (s_ctrlport_req_wr || s_ctrlport_req_rd) begin
      table_addr    <= s_ctrlport_req_addr[`LED_ATR_INDEX_W+1:2];
      table_wr_data <= s_ctrlport_req_data[`LED_SIZE-1:0];
    end
    if (s_ctrlport_req_rd) begin
      rd_addr <= s_ctrlport_req_addr;
    end
    if (s_ctrlport_req_wr || rd_pipe[1]) begin
      s_ctrlport_resp_status <= dec_status;
      // writes return no data
      s_ctrlport_resp_data   <= s_ctrlport_req_wr ? '0 : rd_value;
    end
  end

endmodule

`default_nettype wire

/* rtl/led_atr_pkg.sv */
// shared types of the LED ATR block
// status encoding follows the usual control-port response codes

`default_nettype none

`include "led_atr_settings.svh"

package led_atr_pkg;

  // control-port response status
  typedef enum logic [1:0] {
    sts_okay    = 2'b00,
    sts_cmd_err = 2'b01,
    sts_ts_err  = 2'b10,
    sts_slv_err = 2'b11
  } ctrl_status_e;

  // CPLD writer FSM
  typedef enum logic {
    idle     = 1'b0,
    wait_ack = 1'b1
  } writer_state_e;

  // one channel's LEDs
  // bit 0 RX2, bit 1 TX/RX red, bit 2 TX/RX green
  typedef logic [`LED_SIZE-1:0] led_state_t;

endpackage

`default_nettype wire

/* rtl/led_atr_settings.svh */
// fixed register map of the LED ATR block, one window on the slave control port
// table entries sit at word offsets, channel in addr 11:10, index in addr 9:2
// the CPLD LED register address is fixed, with no run-time relocation

`ifndef LED_ATR_SETTINGS_SVH
`define LED_ATR_SETTINGS_SVH

// control port bus widths
`define CTRLPORT_ADDR_W 20
`define CTRLPORT_DATA_W 32

// --------------------
// register window
`define LED_ATR_REG_BASE 'h2000
`define LED_ATR_REG_SIZE 'h2000
// ATR table region starts at offset 0
`define LED_ATR_STATE_SPAN 'h1000
`define LED_ATR_OPTION_OFFSET 'h1000
`define LED_ATR_DISABLE_OFFSET 'h1004

// --------------------
// table and channel geometry, 256 entries per channel
`define LED_ATR_INDEX_W 8
`define LED_SIZE 3
`define LED_NUM_CH 4

// LED register inside the board CPLD
`define LED_CPLD_REG_ADDR 20'h00000

`endif
